//--- hdl/axiMemPkg.sv
/*
  AXI4 memory slave shared definitions
  Field types for burst length, size and type, response codes, and the
  default bus and memory sizes used by the top level and testbench.
*/
`default_nettype none

package axiMemPkg;

  // AXI4 burst length field (beats minus one)
  typedef logic [7:0] burstLenT;

  // bytes per beat, encoded as log2
  typedef logic [2:0] burstSizeT;

  typedef enum logic [1:0] {
    BurstFixed = 2'b00,
    BurstIncr  = 2'b01,
    BurstWrap  = 2'b10, // held like FIXED here
    BurstRsvd  = 2'b11
  } burstT;

  typedef enum logic [1:0] {
    RespOkay   = 2'b00,
    RespSlvErr = 2'b10
  } respT;

  //--------------------------------------------------------------------
  // default sizes
  //--------------------------------------------------------------------
  localparam int DefaultDataWidth   = 32;
  localparam int DefaultAddrWidth   = 32;
  localparam int DefaultIdWidth     = 4;
  localparam int DefaultSizeInBytes = 1024;

endpackage

`default_nettype wire

//--- hdl/burstTracker.sv
/*
  Burst address tracker
  Holds the beat address and beat count of one AXI burst. A load captures
  the start of a new burst, a step moves to the next beat. INCR advances by
  the transfer size, all other burst types hold the address.
*/
`timescale 1ns/10ps
`default_nettype none

module burstTracker #(
  parameter int DataWidth     = 32,
  parameter int ByteAddrWidth = 10
) (
  input  wire                       ACLK,
  input  wire                       ARESETn,
  input  wire                       load,
  input  wire                       step,
  input  wire [ByteAddrWidth-1:0]   startAddr,
  input  wire axiMemPkg::burstSizeT size,
  input  wire axiMemPkg::burstT     burst,
  input  wire axiMemPkg::burstLenT  len,
  output logic [ByteAddrWidth-1:0]  addr,
  output logic                      lastBeat
);
  import axiMemPkg::*;

  localparam int StrbWidth = DataWidth / 8;

  logic [ByteAddrWidth-1:0] addrQ, curAddr, nextAddr;
  burstSizeT                sizeQ, curSize;
  burstT                    burstQ, curBurst;
  burstLenT                 lenQ, beatQ, curBeat;

  // a load bypasses the registers so a step may follow in the same cycle
  always_comb begin
    curAddr  = load ? startAddr : addrQ;
    curSize  = load ? size : sizeQ;
    curBurst = load ? burst : burstQ;
    curBeat  = load ? '0 : beatQ;
  end

  always_comb begin
    nextAddr = curAddr; // FIXED, WRAP and reserved hold
    if (curBurst == BurstIncr) begin
      if ((32'd1 << curSize) < StrbWidth) begin
        nextAddr = curAddr + (ByteAddrWidth'(1) << curSize);
      end else begin
        nextAddr = (curAddr | ByteAddrWidth'(StrbWidth - 1)) + 1'b1; // next aligned word
      end
    end
  end

  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      addrQ  <= '0;
      beatQ  <= '0;
      lenQ   <= '0;
      sizeQ  <= '0;
      burstQ <= BurstFixed;
    end else begin
      if (load) begin
        sizeQ  <= size;
        burstQ <= burst;
        lenQ   <= len;
      end
      if (step) begin
        addrQ <= nextAddr;
        beatQ <= curBeat + 1'b1;
      end else if (load) begin
        addrQ <= startAddr;
        beatQ <= '0;
      end
    end
  end

  assign addr     = curAddr;
  assign lastBeat = (beatQ == lenQ); // valid from the cycle after load

endmodule

`default_nettype wire

//--- hdl/axiMemArray.sv
/*
  Byte-enabled word memory
  One clocked write port with byte strobes and one combinational read
  port. A read in the same cycle as a write to that word sees the old value.
*/
`timescale 1ns/10ps
`default_nettype none

module axiMemArray #(
  parameter int DataWidth     = 32,
  parameter int ByteAddrWidth = 10
) (
  input  wire                     ACLK,
  input  wire                     wrEn,
  input  wire [ByteAddrWidth-1:0] wrAddr,
  input  wire [DataWidth-1:0]     wrData,
  input  wire [DataWidth/8-1:0]   wrStrb,
  input  wire [ByteAddrWidth-1:0] rdAddr,
  output logic [DataWidth-1:0]    rdData
);

  localparam int StrbWidth  = DataWidth / 8;
  localparam int StrbBits   = $clog2(StrbWidth);
  localparam int IndexWidth = ByteAddrWidth - StrbBits;
  localparam int Depth      = 1 << IndexWidth;

  logic [DataWidth-1:0]  mem [Depth];
  logic [IndexWidth-1:0] wrIdx, rdIdx;

  // word index, byte lane bits dropped
  assign wrIdx = wrAddr[ByteAddrWidth-1:StrbBits];
  assign rdIdx = rdAddr[ByteAddrWidth-1:StrbBits];

  always_ff @(posedge ACLK) begin
    if (wrEn) begin
      for (int b = 0; b < StrbWidth; b++) begin
        if (wrStrb[b]) begin
          mem[wrIdx][8*b +: 8] <= wrData[8*b +: 8];
        end
      end
    end
  end

  assign rdData = mem[rdIdx];

endmodule

`default_nettype wire

//--- hdl/axiWriteChannel.sv
/*
  AXI4 write channel controller
  Accepts one AW request at a time, paces W beats with the setup and burst
  delays, writes each beat to the array and returns the B response.
  The beat count follows AWLEN; a final beat without WLAST gets SLVERR.
*/
`timescale 1ns/10ps
`default_nettype none

module axiWriteChannel #(
  parameter int IdWidth         = 4,
  parameter int AddrWidth       = 32,
  parameter int DataWidth       = 32,
  parameter int DelayWriteSetup = 0,
  parameter int DelayWriteBurst = 0
) (
  input  wire                        ACLK,
  input  wire                        ARESETn,
  input  wire [IdWidth-1:0]          AWID,
  input  wire [AddrWidth-1:0]        AWADDR,
  input  wire axiMemPkg::burstLenT   AWLEN,
  input  wire axiMemPkg::burstSizeT  AWSIZE,
  input  wire axiMemPkg::burstT      AWBURST,
  input  wire                        AWVALID,
  output logic                       AWREADY,
  input  wire [DataWidth-1:0]        WDATA,
  input  wire [DataWidth/8-1:0]      WSTRB,
  input  wire                        WLAST,
  input  wire                        WVALID,
  output logic                       WREADY,
  output logic [IdWidth-1:0]         BID,
  output axiMemPkg::respT            BRESP,
  output logic                       BVALID,
  input  wire                        BREADY,
  output logic                       trkLoad,
  output logic                       trkStep,
  output logic [AddrWidth-1:0]       trkStartAddr,
  output axiMemPkg::burstSizeT       trkSize,
  output axiMemPkg::burstT           trkBurst,
  output axiMemPkg::burstLenT        trkLen,
  input  wire                        trkLast,
  output logic                       wrEn,
  output logic [DataWidth-1:0]       wrData,
  output logic [DataWidth/8-1:0]     wrStrb
);
  import axiMemPkg::*;

  localparam int DelayMax   = (DelayWriteSetup > DelayWriteBurst) ? DelayWriteSetup
                                                                  : DelayWriteBurst;
  localparam int DelayWidth = $clog2(DelayMax + 2);

  typedef enum logic [1:0] {WrIdle, WrDelay, WrWrite, WrResp} wrStateT;

  wrStateT               state;
  logic [DelayWidth-1:0] delayCnt;
  logic                  awFire, wBeat;

  assign awFire = AWVALID && AWREADY && (state == WrIdle);
  assign wBeat  = WVALID && WREADY && (state == WrWrite);

  // tracker captures the request itself on load
  assign trkLoad      = awFire;
  assign trkStep      = wBeat;
  assign trkStartAddr = AWADDR;
  assign trkSize      = AWSIZE;
  assign trkBurst     = AWBURST;
  assign trkLen       = AWLEN;

  assign wrEn   = wBeat;
  assign wrData = WDATA;
  assign wrStrb = WSTRB;

  //--------------------------------------------------------------------
  // write FSM
  //--------------------------------------------------------------------
  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      state    <= WrIdle;
      AWREADY  <= 1'b0;
      WREADY   <= 1'b0;
      BVALID   <= 1'b0;
      BRESP    <= RespOkay;
      delayCnt <= '0;
    end else begin
      case (state)
        WrIdle: begin
          if (awFire) begin
            AWREADY <= 1'b0;
            BRESP   <= RespOkay;
            if (DelayWriteSetup == 0) begin
              WREADY <= 1'b1;
              state  <= WrWrite;
            end else begin
              delayCnt <= DelayWidth'(DelayWriteSetup - 1);
              state    <= WrDelay;
            end
          end else begin
            AWREADY <= 1'b1;
          end
        end
        WrDelay: begin
          delayCnt <= delayCnt - 1'b1;
          if (delayCnt == '0) begin
            WREADY <= 1'b1;
            state  <= WrWrite;
          end
        end
        WrWrite: begin
          if (wBeat) begin
            if (trkLast) begin
              WREADY <= 1'b0;
              BVALID <= 1'b1;
              if (!WLAST) BRESP <= RespSlvErr; // last beat came without WLAST
              state <= WrResp;
            end else if (DelayWriteBurst != 0) begin
              WREADY   <= 1'b0;
              delayCnt <= DelayWidth'(DelayWriteBurst - 1);
              state    <= WrDelay;
            end
          end
        end
        WrResp: begin
          if (BREADY) begin
            BVALID  <= 1'b0;
            AWREADY <= 1'b1;
            state   <= WrIdle;
          end
        end
        default: state <= WrIdle;
      endcase
    end
  end

  always_ff @(posedge ACLK) begin
    if (awFire) BID <= AWID;
  end

endmodule

`default_nettype wire

//--- hdl/axiReadChannel.sv
/*
  AXI4 read channel controller
  Accepts one AR request at a time and returns its beats on R. Each word
  is fetched from the array into RDATA after the setup delay, then after
  every accepted beat, immediately or after the burst delay.
*/
`timescale 1ns/10ps
`default_nettype none

module axiReadChannel #(
  parameter int IdWidth        = 4,
  parameter int DataWidth      = 32,
  parameter int DelayReadSetup = 0,
  parameter int DelayReadBurst = 0
) (
  input  wire                      ACLK,
  input  wire                      ARESETn,
  input  wire [IdWidth-1:0]        ARID,
  input  wire axiMemPkg::burstLenT ARLEN,
  input  wire                      ARVALID,
  output logic                     ARREADY,
  output logic [IdWidth-1:0]       RID,
  output logic [DataWidth-1:0]     RDATA,
  output axiMemPkg::respT          RRESP,
  output logic                     RLAST,
  output logic                     RVALID,
  input  wire                      RREADY,
  output logic                     trkLoad,
  output logic                     trkStep,
  input  wire                      trkLast,
  input  wire [DataWidth-1:0]      rdData
);
  import axiMemPkg::*;

  localparam int DelayMax   = (DelayReadSetup > DelayReadBurst) ? DelayReadSetup
                                                                : DelayReadBurst;
  localparam int DelayWidth = $clog2(DelayMax + 2);

  typedef enum logic [1:0] {RdIdle, RdDelay, RdRead, RdEnd} rdStateT;

  rdStateT               state;
  logic [DelayWidth-1:0] delayCnt;
  logic                  arFire, fetch, lastFetch;

  assign arFire = ARVALID && ARREADY && (state == RdIdle);

  // fetch: the next array word goes into RDATA at this edge
  always_comb begin
    case (state)
      RdIdle:  fetch = arFire && (DelayReadSetup == 0);
      RdDelay: fetch = (delayCnt == '0);
      RdRead:  fetch = RREADY && (DelayReadBurst == 0);
      default: fetch = 1'b0;
    endcase
  end

  // tracker count is not loaded yet on the request edge
  assign lastFetch = (state == RdIdle) ? (ARLEN == '0) : trkLast;

  assign trkLoad = arFire;
  assign trkStep = fetch;
  assign RRESP   = RespOkay;

  //--------------------------------------------------------------------
  // read FSM
  //--------------------------------------------------------------------
  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      state    <= RdIdle;
      ARREADY  <= 1'b0;
      RVALID   <= 1'b0;
      RLAST    <= 1'b0;
      delayCnt <= '0;
    end else begin
      if (fetch) begin
        RVALID <= 1'b1;
        RLAST  <= lastFetch;
        state  <= lastFetch ? RdEnd : RdRead;
      end
      case (state)
        RdIdle: begin
          if (arFire) begin
            ARREADY <= 1'b0;
            if (DelayReadSetup != 0) begin
              delayCnt <= DelayWidth'(DelayReadSetup - 1);
              state    <= RdDelay;
            end
          end else begin
            ARREADY <= 1'b1;
          end
        end
        RdDelay: delayCnt <= delayCnt - 1'b1;
        RdRead: begin
          if (RREADY && (DelayReadBurst != 0)) begin
            RVALID   <= 1'b0;
            delayCnt <= DelayWidth'(DelayReadBurst); // low for burst delay plus one
            state    <= RdDelay;
          end
        end
        RdEnd: begin
          if (RREADY) begin
            RVALID  <= 1'b0;
            RLAST   <= 1'b0;
            ARREADY <= 1'b1;
            state   <= RdIdle;
          end
        end
        default: state <= RdIdle;
      endcase
    end
  end

  always_ff @(posedge ACLK) begin
    if (arFire) RID <= ARID;
    if (fetch) RDATA <= rdData; // read-first against a same-edge write
  end

endmodule

`default_nettype wire

//--- hdl/axiMemSlave.sv
/*
  AXI4 slave memory model, top level
  Write and read channel controllers run concurrently, each with its own
  burst tracker, over one byte-enabled word array.
*/
`timescale 1ns/10ps
`default_nettype none

module axiMemSlave #(
  parameter int DataWidth       = axiMemPkg::DefaultDataWidth,
  parameter int AddrWidth       = axiMemPkg::DefaultAddrWidth,
  parameter int IdWidth         = axiMemPkg::DefaultIdWidth,
  parameter int SizeInBytes     = axiMemPkg::DefaultSizeInBytes,
  parameter int DelayWriteSetup = 0,
  parameter int DelayWriteBurst = 0,
  parameter int DelayReadSetup  = 0,
  parameter int DelayReadBurst  = 0
) (
  input  wire                       ACLK,
  input  wire                       ARESETn,
  // write address
  input  wire [IdWidth-1:0]         AWID,
  input  wire [AddrWidth-1:0]       AWADDR,
  input  wire axiMemPkg::burstLenT  AWLEN,
  input  wire axiMemPkg::burstSizeT AWSIZE,
  input  wire axiMemPkg::burstT     AWBURST,
  input  wire                       AWVALID,
  output logic                      AWREADY,
  // write data
  input  wire [DataWidth-1:0]       WDATA,
  input  wire [DataWidth/8-1:0]     WSTRB,
  input  wire                       WLAST,
  input  wire                       WVALID,
  output logic                      WREADY,
  // write response
  output logic [IdWidth-1:0]        BID,
  output axiMemPkg::respT           BRESP,
  output logic                      BVALID,
  input  wire                       BREADY,
  // read address
  input  wire [IdWidth-1:0]         ARID,
  input  wire [AddrWidth-1:0]       ARADDR,
  input  wire axiMemPkg::burstLenT  ARLEN,
  input  wire axiMemPkg::burstSizeT ARSIZE,
  input  wire axiMemPkg::burstT     ARBURST,
  input  wire                       ARVALID,
  output logic                      ARREADY,
  // read data
  output logic [IdWidth-1:0]        RID,
  output logic [DataWidth-1:0]      RDATA,
  output axiMemPkg::respT           RRESP,
  output logic                      RLAST,
  output logic                      RVALID,
  input  wire                       RREADY
);
  import axiMemPkg::*;

  localparam int StrbWidth     = DataWidth / 8;
  localparam int StrbBits      = $clog2(StrbWidth);
  localparam int IndexWidth    = $clog2(SizeInBytes) - StrbBits; // word index bits
  localparam int ByteAddrWidth = IndexWidth + StrbBits;

  logic                     wrTrkLoad, wrTrkStep, wrTrkLast;
  logic [AddrWidth-1:0]     wrTrkStart;
  logic [ByteAddrWidth-1:0] wrTrkAddr;
  burstSizeT                wrTrkSize;
  burstT                    wrTrkBurst;
  burstLenT                 wrTrkLen;
  logic                     memWrEn;
  logic [DataWidth-1:0]     memWrData;
  logic [StrbWidth-1:0]     memWrStrb;

  logic                     rdTrkLoad, rdTrkStep, rdTrkLast;
  logic [ByteAddrWidth-1:0] rdTrkAddr;
  logic [DataWidth-1:0]     memRdData;

  //--------------------------------------------------------------------
  // write side
  //--------------------------------------------------------------------
  axiWriteChannel #(
    .IdWidth(IdWidth), .AddrWidth(AddrWidth), .DataWidth(DataWidth),
    .DelayWriteSetup(DelayWriteSetup), .DelayWriteBurst(DelayWriteBurst)
  ) uWrite (
    .ACLK(ACLK), .ARESETn(ARESETn),
    .AWID(AWID), .AWADDR(AWADDR), .AWLEN(AWLEN), .AWSIZE(AWSIZE),
    .AWBURST(AWBURST), .AWVALID(AWVALID), .AWREADY(AWREADY),
    .WDATA(WDATA), .WSTRB(WSTRB), .WLAST(WLAST), .WVALID(WVALID), .WREADY(WREADY),
    .BID(BID), .BRESP(BRESP), .BVALID(BVALID), .BREADY(BREADY),
    .trkLoad(wrTrkLoad), .trkStep(wrTrkStep), .trkStartAddr(wrTrkStart),
    .trkSize(wrTrkSize), .trkBurst(wrTrkBurst), .trkLen(wrTrkLen),
    .trkLast(wrTrkLast),
    .wrEn(memWrEn), .wrData(memWrData), .wrStrb(memWrStrb)
  );

  burstTracker #(.DataWidth(DataWidth), .ByteAddrWidth(ByteAddrWidth)) uWrTracker (
    .ACLK(ACLK), .ARESETn(ARESETn),
    .load(wrTrkLoad), .step(wrTrkStep),
    .startAddr(wrTrkStart[ByteAddrWidth-1:0]),
    .size(wrTrkSize), .burst(wrTrkBurst), .len(wrTrkLen),
    .addr(wrTrkAddr), .lastBeat(wrTrkLast)
  );

  //--------------------------------------------------------------------
  // read side
  //--------------------------------------------------------------------
  axiReadChannel #(
    .IdWidth(IdWidth), .DataWidth(DataWidth),
    .DelayReadSetup(DelayReadSetup), .DelayReadBurst(DelayReadBurst)
  ) uRead (
    .ACLK(ACLK), .ARESETn(ARESETn),
    .ARID(ARID), .ARLEN(ARLEN), .ARVALID(ARVALID), .ARREADY(ARREADY),
    .RID(RID), .RDATA(RDATA), .RRESP(RRESP), .RLAST(RLAST),
    .RVALID(RVALID), .RREADY(RREADY),
    .trkLoad(rdTrkLoad), .trkStep(rdTrkStep), .trkLast(rdTrkLast),
    .rdData(memRdData)
  );

  burstTracker #(.DataWidth(DataWidth), .ByteAddrWidth(ByteAddrWidth)) uRdTracker (
    .ACLK(ACLK), .ARESETn(ARESETn),
    .load(rdTrkLoad), .step(rdTrkStep),
    .startAddr(ARADDR[ByteAddrWidth-1:0]), // AR fields go straight in
    .size(ARSIZE), .burst(ARBURST), .len(ARLEN),
    .addr(rdTrkAddr), .lastBeat(rdTrkLast)
  );

  axiMemArray #(.DataWidth(DataWidth), .ByteAddrWidth(ByteAddrWidth)) uArray (
    .ACLK(ACLK),
    .wrEn(memWrEn), .wrAddr(wrTrkAddr), .wrData(memWrData), .wrStrb(memWrStrb),
    .rdAddr(rdTrkAddr), .rdData(memRdData)
  );

endmodule

`default_nettype wire

//--- testbench/tbAxiMemSlave.sv
/*
  Testbench for the AXI4 slave memory model
  Runs the transactions of the case file as an AXI master with random
  BREADY and RREADY back-pressure. B and R responses and read data are
  checked against a byte-wide reference memory.
*/
`timescale 1ns/10ps
`default_nettype none

module tbAxiMemSlave;
  import axiMemPkg::*;

  localparam int DataWidth   = DefaultDataWidth;
  localparam int AddrWidth   = DefaultAddrWidth;
  localparam int IdWidth     = DefaultIdWidth;
  localparam int SizeInBytes = DefaultSizeInBytes;
  localparam int StrbWidth   = DataWidth / 8;
  localparam int CaseFields  = 9; // op id addr len size burst strb noLast resp
  localparam int MaxCases    = 64;

  logic                 ACLK, ARESETn;
  logic [IdWidth-1:0]   AWID, BID, ARID, RID;
  logic [AddrWidth-1:0] AWADDR, ARADDR;
  burstLenT             AWLEN, ARLEN;
  burstSizeT            AWSIZE, ARSIZE;
  burstT                AWBURST, ARBURST;
  logic [DataWidth-1:0] WDATA, RDATA;
  logic [StrbWidth-1:0] WSTRB;
  respT                 BRESP, RRESP;
  logic                 AWVALID, AWREADY, WLAST, WVALID, WREADY, BVALID, BREADY;
  logic                 ARVALID, ARREADY, RLAST, RVALID, RREADY;

  logic [31:0] caseMem [CaseFields*MaxCases];
  logic [7:0]  refMem [SizeInBytes]; // byte-wide reference model
  logic [31:0] rngState;
  int          errors, testsRun, testsFailed, cycleCount, cycleLimit;

  axiMemSlave #(
    .DataWidth(DataWidth), .AddrWidth(AddrWidth), .IdWidth(IdWidth),
    .SizeInBytes(SizeInBytes), .DelayWriteSetup(2), .DelayWriteBurst(1),
    .DelayReadSetup(1), .DelayReadBurst(0)
  ) UUT (.*);

  always #20 ACLK = ~ACLK;

  always @(posedge ACLK) begin
    cycleCount <= cycleCount + 1;
    if (cycleLimit != 0 && cycleCount > cycleLimit) begin
      $display("Timeout after %0d cycles, a handshake never completed", cycleCount);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  //--------------------------------------------------------------------
  // helpers
  //--------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // INCR moves by the size, full width to the next word; others hold
  function automatic logic [AddrWidth-1:0] nextBeatAddr(input logic [AddrWidth-1:0] a,
                                                         input burstSizeT size,
                                                         input burstT burst);
    int nBytes;
    nBytes = 1 << size;
    if (burst != BurstIncr) return a;
    if (nBytes < StrbWidth) return a + nBytes;
    return a - (a % StrbWidth) + StrbWidth;
  endfunction

  // narrow beats use their own lanes, held bursts rotate the mask per beat
  function automatic logic [StrbWidth-1:0] beatStrobe(input logic [AddrWidth-1:0] a,
      input burstSizeT size, input burstT burst, input logic [StrbWidth-1:0] mask,
      input int beat);
    logic [StrbWidth-1:0] lanes;
    int nBytes, first, k;
    nBytes = 1 << size;
    lanes  = mask;
    if (nBytes < StrbWidth) begin
      lanes = '0;
      first = a % StrbWidth;
      for (k = 0; k < nBytes; k++) lanes[(first + k) % StrbWidth] = 1'b1;
      lanes = lanes & mask;
    end else if (burst != BurstIncr) begin
      for (k = 0; k < beat % StrbWidth; k++) lanes = {lanes[StrbWidth-2:0], lanes[StrbWidth-1]};
    end
    return lanes;
  endfunction

  function automatic logic [DataWidth-1:0] refWord(input logic [AddrWidth-1:0] a);
    logic [DataWidth-1:0] w;
    int base, k;
    base = (a % SizeInBytes) & ~(StrbWidth - 1);
    for (k = 0; k < StrbWidth; k++) w[8*k +: 8] = refMem[base + k];
    return w;
  endfunction

  task automatic storeBeat(input logic [AddrWidth-1:0] a, input logic [DataWidth-1:0] data,
                           input logic [StrbWidth-1:0] strb);
    int base, k;
    base = (a % SizeInBytes) & ~(StrbWidth - 1);
    for (k = 0; k < StrbWidth; k++) begin
      if (strb[k]) refMem[base + k] = data[8*k +: 8];
    end
  endtask

  //--------------------------------------------------------------------
  // compare tasks
  //--------------------------------------------------------------------
  task automatic checkData(input logic [DataWidth-1:0] got, exp, input string name);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic checkResp(input respT got, exp, input string name);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic checkId(input logic [IdWidth-1:0] got, exp, input string name);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic checkFlag(input logic got, exp, input string name);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic reportTest(input string what, input int errBefore);
    testsRun++;
    if (errors == errBefore) begin
      $display("test %0d %s: ok", testsRun, what);
    end else begin
      testsFailed++;
      $display("test %0d %s: %0d errors", testsRun, what, errors - errBefore);
    end
  endtask

  //--------------------------------------------------------------------
  // AXI master transfers, entered and left on a rising edge
  //--------------------------------------------------------------------
  task automatic doWrite(input logic [IdWidth-1:0] id, input logic [AddrWidth-1:0] addr,
                         input burstLenT len, input burstSizeT size, input burstT burst,
                         input logic [StrbWidth-1:0] mask, input logic noLast,
                         input respT expResp);
    logic [AddrWidth-1:0] beatAddr;
    logic [DataWidth-1:0] data;
    logic [StrbWidth-1:0] strb;
    logic                 gotB;
    int                   b;
    AWID    <= id;
    AWADDR  <= addr;
    AWLEN   <= len;
    AWSIZE  <= size;
    AWBURST <= burst;
    AWVALID <= 1'b1;
    do @(posedge ACLK); while (!AWREADY);
    AWVALID  <= 1'b0;
    beatAddr = addr;
    for (b = 0; b <= len; b++) begin
      rngState = xorshift32(rngState);
      data     = rngState;
      strb     = beatStrobe(beatAddr, size, burst, mask, b);
      WDATA  <= data;
      WSTRB  <= strb;
      WLAST  <= (b == len) && !noLast;
      WVALID <= 1'b1;
      do @(posedge ACLK); while (!WREADY); // beat taken at this edge
      storeBeat(beatAddr, data, strb);
      beatAddr = nextBeatAddr(beatAddr, size, burst);
    end
    WVALID <= 1'b0;
    WLAST  <= 1'b0;
    gotB   = 1'b0;
    while (!gotB) begin
      rngState = xorshift32(rngState);
      BREADY <= rngState[4];
      @(posedge ACLK);
      if (BVALID && BREADY) begin
        gotB = 1'b1;
        checkId(BID, id, "BID");
        checkResp(BRESP, expResp, "BRESP");
      end
    end
    BREADY <= 1'b0;
  endtask

  task automatic doRead(input logic [IdWidth-1:0] id, input logic [AddrWidth-1:0] addr,
                        input burstLenT len, input burstSizeT size, input burstT burst,
                        input respT expResp);
    logic [AddrWidth-1:0] beatAddr;
    logic                 pending; // RVALID shown but not yet taken
    int                   b;
    ARID    <= id;
    ARADDR  <= addr;
    ARLEN   <= len;
    ARSIZE  <= size;
    ARBURST <= burst;
    ARVALID <= 1'b1;
    do @(posedge ACLK); while (!ARREADY);
    ARVALID  <= 1'b0;
    beatAddr = addr;
    pending  = 1'b0;
    b        = 0;
    while (b <= len) begin
      rngState = xorshift32(rngState);
      RREADY <= rngState[4];
      @(posedge ACLK);
      if (pending && !RVALID) begin
        $display("Error at %0t ns: RVALID dropped before beat %0d was accepted", $time, b);
        errors++;
      end
      pending = RVALID && !RREADY;
      if (RVALID && RREADY) begin
        checkData(RDATA, refWord(beatAddr), "RDATA");
        checkId(RID, id, "RID");
        checkResp(RRESP, expResp, "RRESP");
        checkFlag(RLAST, b == len, "RLAST");
        beatAddr = nextBeatAddr(beatAddr, size, burst);
        b++;
      end
    end
    RREADY <= 1'b0;
  endtask

  task automatic runCase(input int c);
    int          base, errBefore;
    logic [31:0] f [CaseFields];
    string       what;
    base = c * CaseFields;
    for (int k = 0; k < CaseFields; k++) f[k] = caseMem[base + k];
    errBefore = errors;
    what = $sformatf("%s id %h addr %h len %0d size %0d burst %0d", (f[0] == 0) ? "write" : "read",
                     f[1][IdWidth-1:0], f[2], f[3], f[4], f[5]);
    if (f[0] == 0) begin
      doWrite(f[1][IdWidth-1:0], f[2], f[3][7:0], f[4][2:0], burstT'(f[5][1:0]),
              f[6][StrbWidth-1:0], f[7][0], respT'(f[8][1:0]));
    end else begin
      doRead(f[1][IdWidth-1:0], f[2], f[3][7:0], f[4][2:0], burstT'(f[5][1:0]),
             respT'(f[8][1:0]));
    end
    reportTest(what, errBefore);
  endtask

  //--------------------------------------------------------------------
  // main sequence
  //--------------------------------------------------------------------
  initial begin : mainFlow
    int i, numCases, errBefore;
    ACLK        = 1'b0;
    ARESETn     = 1'b0;
    AWID        = '0;
    AWADDR      = '0;
    AWLEN       = '0;
    AWSIZE      = 3'd2;
    AWBURST     = BurstIncr;
    AWVALID     = 1'b0;
    WDATA       = '0;
    WSTRB       = '0;
    WLAST       = 1'b0;
    WVALID      = 1'b0;
    BREADY      = 1'b0;
    ARID        = '0;
    ARADDR      = '0;
    ARLEN       = '0;
    ARSIZE      = 3'd2;
    ARBURST     = BurstIncr;
    ARVALID     = 1'b0;
    RREADY      = 1'b0;
    rngState    = 32'h14b2;
    errors      = 0;
    testsRun    = 0;
    testsFailed = 0;
    cycleCount  = 0;
    cycleLimit  = 0;

    // unread entries keep an op field above 1, which ends the case list
    for (i = 0; i < CaseFields*MaxCases; i++) caseMem[i] = {16'hC0DE, i[15:0]};
    $readmemh("testbench/memCases.txt", caseMem);
    numCases = 0;
    while (numCases < MaxCases && caseMem[numCases*CaseFields] <= 32'd1) numCases++;
    if (numCases == 0) begin
      $display("No transactions found in testbench/memCases.txt");
      errors++;
    end
    cycleLimit = (numCases + 1) * 256 * 8;

    // reset for 8 cycles, outputs checked once the first edge has passed
    errBefore = errors;
    repeat (2) @(posedge ACLK);
    checkFlag(AWREADY, 1'b0, "AWREADY");
    checkFlag(WREADY, 1'b0, "WREADY");
    checkFlag(BVALID, 1'b0, "BVALID");
    checkFlag(ARREADY, 1'b0, "ARREADY");
    checkFlag(RVALID, 1'b0, "RVALID");
    checkFlag(RLAST, 1'b0, "RLAST");
    repeat (6) @(posedge ACLK);
    ARESETn <= 1'b1;
    reportTest("reset outputs", errBefore);

    for (i = 0; i < numCases; i++) runCase(i);

    $display("Done: %0d tests, %0d failed, %0d errors", testsRun, testsFailed, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/memCases.txt
// op id addr len size burst strb noLast resp, all hex, one transaction per line
// op 0 write 1 read; burst 0 FIXED 1 INCR 2 WRAP 3 reserved; resp 0 OKAY 2 SLVERR
// full-width INCR burst and readback
0 3 040 7 2 1 F 0 0
1 5 040 7 2 1 F 0 0
// partial strobes over preloaded words
0 1 100 0 2 1 F 0 0
0 2 100 0 2 1 5 0 0
1 2 100 0 2 1 F 0 0
0 4 104 3 2 1 F 0 0
0 4 104 3 2 1 A 0 0
1 4 104 3 2 1 F 0 0
// FIXED, WRAP and reserved bursts hold the address
0 6 200 0 2 1 F 0 0
0 7 200 5 2 0 1 0 0
1 7 200 0 2 1 F 0 0
0 8 210 0 2 1 F 0 0
0 8 210 2 2 0 3 0 0
1 8 210 2 2 0 F 0 0
0 9 220 3 2 2 F 0 0
1 9 220 0 2 1 F 0 0
0 3 230 0 2 1 F 0 0
0 3 230 1 2 3 9 0 0
1 3 230 0 2 1 F 0 0
// narrow INCR writes merge into full words
0 A 300 3 0 1 F 0 0
1 A 300 0 2 1 F 0 0
1 C 300 3 0 1 F 0 0
0 B 308 3 1 1 F 0 0
1 B 308 1 2 1 F 0 0
// final beat without WLAST
0 D 380 3 2 1 F 1 2
1 D 380 3 2 1 F 0 0
0 E 390 0 2 1 F 1 2
1 E 390 0 2 1 F 0 0
// long bursts under back-pressure
0 F 280 1F 2 1 F 0 0
1 0 280 1F 2 1 F 0 0

//--- compile.f
hdl/axiMemPkg.sv
hdl/burstTracker.sv
hdl/axiMemArray.sv
hdl/axiWriteChannel.sv
hdl/axiReadChannel.sv
hdl/axiMemSlave.sv
testbench/tbAxiMemSlave.sv
